//--- common/z80_pkg.sv
// Z80 execution slice definitions
package z80_pkg;

    localparam int NUM_REGS = 7;

    // register index as it appears in opcode bits 5:3.
    typedef logic [2:0] reg_idx_t;

    localparam reg_idx_t REG_A      = 3'd7;
    localparam reg_idx_t REG_HL_MEM = 3'd6; // memory operand (HL) has no cell behind it.

    // F byte with the most significant bit first.
    typedef struct packed {
        logic s;
        logic z;
        logic y;  // undocumented bit 5 is held at zero.
        logic h;
        logic x;  // undocumented bit 3 is held at zero.
        logic pv;
        logic n;
        logic c;
    } flags_t;

    // accumulator operations in opcode bits 5:3 order.
    typedef enum logic [2:0] {
        RLCA = 3'd0,
        RRCA = 3'd1,
        RLA  = 3'd2,
        RRA  = 3'd3,
        DAA  = 3'd4,
        CPL  = 3'd5,
        SCF  = 3'd6,
        CCF  = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        T_IDLE = 2'd0,
        T1     = 2'd1,
        T2     = 2'd2,
        T3     = 2'd3
    } tstate_t;

    localparam logic [1:0] GRP_TOP    = 2'b00;  // opcode bits 7:6.
    localparam logic [2:0] GRP_LD_IMM = 3'b110; // opcode bits 2:0.
    localparam logic [2:0] GRP_ACC    = 3'b111;

    localparam logic [7:0] DAA_CORR_LO = 8'h06;
    localparam logic [7:0] DAA_CORR_HI = 8'h60;

    // A sits in the last cell slot while B to L keep their own index.
    function automatic logic [2:0] cell_slot(reg_idx_t r);
        return (r == REG_A) ? 3'(NUM_REGS - 1) : r;
    endfunction

endpackage

//--- logic/reg_cell.sv
// Generic storage cell
`timescale 1ns/1ns

module reg_cell #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (we) begin
            q <= d;
        end
    end

endmodule

//--- logic/read_mux.sv
// Register file read port
`timescale 1ns/1ns

module read_mux (
    input  logic [z80_pkg::NUM_REGS-1:0][7:0] cells,
    input  z80_pkg::reg_idx_t                 rd_sel,
    output logic [7:0]                        rd_data
);

    logic [2:0] slot;

    assign slot = z80_pkg::cell_slot(rd_sel);

    always_comb begin
        if (rd_sel == z80_pkg::REG_HL_MEM) begin
            rd_data = '0; // no memory behind (HL).
        end else begin
            rd_data = cells[slot];
        end
    end

endmodule

//--- logic/timing_sequencer.sv
// Instruction timing sequencer
`timescale 1ns/1ns

module timing_sequencer (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [7:0]       opcode,
    input  logic [7:0]       operand,
    output z80_pkg::tstate_t state,
    output logic [7:0]       op_q,
    output logic [7:0]       imm_q,
    output logic             busy,
    output logic             done
);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= z80_pkg::T_IDLE;
        end else begin
            case (state)
                z80_pkg::T_IDLE: if (start) state <= z80_pkg::T1;
                z80_pkg::T1:     state <= z80_pkg::T2;
                z80_pkg::T2:     state <= z80_pkg::T3; // decode state.
                default:         state <= z80_pkg::T_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            op_q  <= opcode;
            imm_q <= operand;
        end
    end

    assign busy = (state != z80_pkg::T_IDLE); // a start while busy is dropped.
    assign done = (state == z80_pkg::T3);

endmodule

//--- decoder/op_decoder.sv
// Opcode and timing state decoder
`timescale 1ns/1ns

module op_decoder (
    input  z80_pkg::tstate_t             state,
    input  logic [7:0]                   op_q,
    output logic [z80_pkg::NUM_REGS-1:0] reg_we,
    output logic                         acc_we,
    output logic                         flag_we,
    output z80_pkg::alu_op_t             alu_op,
    output logic                         mem_write,
    output logic                         illegal
);

    logic     t3;
    logic     top_t3;
    logic     ld_imm_t3;
    logic     acc_t3;
    logic     mem_dst;
    logic [2:0] ld_slot;

    // the whole group tree acts only in T3.
    assign t3     = (state == z80_pkg::T3);
    assign top_t3 = t3 && (op_q[7:6] == z80_pkg::GRP_TOP);

    // second level on bits 2:0.
    assign ld_imm_t3 = top_t3 && (op_q[2:0] == z80_pkg::GRP_LD_IMM);
    assign acc_t3    = top_t3 && (op_q[2:0] == z80_pkg::GRP_ACC);

    assign mem_dst = (op_q[5:3] == z80_pkg::REG_HL_MEM);
    assign ld_slot = z80_pkg::cell_slot(op_q[5:3]);

    assign alu_op    = z80_pkg::alu_op_t'(op_q[5:3]); // operation field is bits 5:3.
    assign acc_we    = acc_t3;
    assign flag_we   = acc_t3;
    assign mem_write = ld_imm_t3 && mem_dst;
    assign illegal   = t3 && !ld_imm_t3 && !acc_t3;

    always_comb begin
        reg_we = '0;
        if (ld_imm_t3 && !mem_dst) begin
            reg_we[ld_slot] = 1'b1;
        end
        if (acc_t3) begin
            reg_we[z80_pkg::cell_slot(z80_pkg::REG_A)] = acc_we; // the ALU owns A here.
        end
    end

endmodule

//--- alu/accum_alu.sv
// Accumulator and flag ALU
`timescale 1ns/1ns

module accum_alu (
    input  logic [7:0]       a,
    input  z80_pkg::flags_t  f_in,
    input  z80_pkg::alu_op_t op,
    output logic [7:0]       result,
    output z80_pkg::flags_t  f_out
);

    logic       lo_adj;
    logic       hi_adj;
    logic [7:0] corr;
    logic [7:0] daa_res;
    logic       daa_h;

    assign lo_adj = f_in.h || (a[3:0] > 4'd9);
    assign hi_adj = f_in.c || (a > 8'h99);

    // 0x06, 0x60 or both together as 0x66.
    always_comb begin
        corr = '0;
        if (lo_adj) begin
            corr = corr | z80_pkg::DAA_CORR_LO;
        end
        if (hi_adj) begin
            corr = corr | z80_pkg::DAA_CORR_HI;
        end
    end

    assign daa_res = f_in.n ? (a - corr) : (a + corr);
    assign daa_h   = f_in.n ? (f_in.h && (a[3:0] < 4'd6)) : (a[3:0] > 4'd9);

    always_comb begin
        result = a;
        f_out  = f_in;
        case (op)
            z80_pkg::RLCA: begin
                result  = {a[6:0], a[7]};
                f_out.c = a[7];
            end
            z80_pkg::RRCA: begin
                result  = {a[0], a[7:1]};
                f_out.c = a[0];
            end
            z80_pkg::RLA: begin
                result  = {a[6:0], f_in.c}; // rotate through carry.
                f_out.c = a[7];
            end
            z80_pkg::RRA: begin
                result  = {f_in.c, a[7:1]};
                f_out.c = a[0];
            end
            z80_pkg::DAA: begin
                result   = daa_res;
                f_out.s  = daa_res[7];
                f_out.z  = (daa_res == 8'h00);
                f_out.h  = daa_h;
                f_out.pv = ~^daa_res; // even parity.
                f_out.c  = hi_adj;
            end
            z80_pkg::CPL: begin
                result  = ~a;
                f_out.h = 1'b1;
                f_out.n = 1'b1;
            end
            z80_pkg::SCF: f_out.c = 1'b1;
            default: begin
                f_out.c = ~f_in.c;
                f_out.h = f_in.c; // CCF moves the old carry into H.
            end
        endcase
        if (op inside {z80_pkg::RLCA, z80_pkg::RRCA, z80_pkg::RLA, z80_pkg::RRA,
                       z80_pkg::SCF}) begin
            f_out.h = 1'b0;
        end
        if (op != z80_pkg::CPL && op != z80_pkg::DAA) begin
            f_out.n = 1'b0;
        end
        f_out.y = 1'b0;
        f_out.x = 1'b0;
    end

endmodule

//--- logic/z80_exec_top.sv
// Z80 execution slice top
`timescale 1ns/1ns

module z80_exec_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [7:0]        opcode,
    input  logic [7:0]        operand,
    output logic              busy,
    output logic              done,
    output logic              illegal,
    output logic              mem_write,
    input  z80_pkg::reg_idx_t rd_sel,
    output logic [7:0]        rd_data,
    output z80_pkg::flags_t   flags
);

    z80_pkg::tstate_t                 state;
    logic [7:0]                       op_q;
    logic [7:0]                       imm_q;
    logic [z80_pkg::NUM_REGS-1:0]     reg_we;
    logic                             acc_we;
    logic                             flag_we;
    z80_pkg::alu_op_t                 alu_op;
    logic [7:0]                       alu_result;
    z80_pkg::flags_t                  alu_flags;
    logic [7:0]                       a_d;
    logic [z80_pkg::NUM_REGS-1:0][7:0] cells;

    timing_sequencer u_seq (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .opcode  (opcode),
        .operand (operand),
        .state   (state),
        .op_q    (op_q),
        .imm_q   (imm_q),
        .busy    (busy),
        .done    (done)
    );

    op_decoder u_dec (
        .state     (state),
        .op_q      (op_q),
        .reg_we    (reg_we),
        .acc_we    (acc_we),
        .flag_we   (flag_we),
        .alu_op    (alu_op),
        .mem_write (mem_write),
        .illegal   (illegal)
    );

    accum_alu u_alu (
        .a      (cells[z80_pkg::NUM_REGS-1]),
        .f_in   (flags),
        .op     (alu_op),
        .result (alu_result),
        .f_out  (alu_flags)
    );

    assign a_d = acc_we ? alu_result : imm_q; // A loads from the ALU or the immediate.

    for (genvar i = 0; i < z80_pkg::NUM_REGS; i++) begin : g_cell
        reg_cell #(.payload_t(logic [7:0])) u_cell (
            .clk   (clk),
            .reset (reset),
            .we    (reg_we[i]),
            .d     ((i == z80_pkg::NUM_REGS - 1) ? a_d : imm_q),
            .q     (cells[i])
        );
    end

    reg_cell #(.payload_t(z80_pkg::flags_t)) u_flag_cell (
        .clk   (clk),
        .reset (reset),
        .we    (flag_we),
        .d     (alu_flags),
        .q     (flags)
    );

    read_mux u_rd (
        .cells   (cells),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

endmodule

//--- dv/tb_clock.sv
// Testbench clock
`timescale 1ns/1ns

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

endmodule

//--- dv/exec_chk.sv
// Sequencing and strobe assertions
`timescale 1ns/1ns

module exec_chk (
    input logic                         clk,
    input logic                         reset,
    input z80_pkg::tstate_t             state,
    input logic                         busy,
    input logic                         done,
    input logic [z80_pkg::NUM_REGS-1:0] reg_we,
    input logic                         acc_we,
    input logic                         flag_we,
    input logic                         mem_write
);

    a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_we_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(reg_we))
        else $error("more than one register write strobe is high");

    a_strobe_t3: assert property (@(posedge clk) disable iff (reset)
        (state != z80_pkg::T3) |-> !(|reg_we || acc_we || flag_we || mem_write))
        else $error("write strobe high outside T3");

    a_busy_drop: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> $past(done))
        else $error("busy dropped without done");

endmodule

bind z80_exec_top exec_chk chk (
    .clk       (clk),
    .reset     (reset),
    .state     (state),
    .busy      (busy),
    .done      (done),
    .reg_we    (reg_we),
    .acc_we    (acc_we),
    .flag_we   (flag_we),
    .mem_write (mem_write)
);

//--- dv/exec_tb.sv
// Execution slice testbench
`timescale 1ns/1ns

module exec_tb;

    logic              clk;
    logic              reset;
    logic              start;
    logic [7:0]        opcode;
    logic [7:0]        operand;
    logic              busy;
    logic              done;
    logic              illegal;
    logic              mem_write;
    z80_pkg::reg_idx_t rd_sel;
    logic [7:0]        rd_data;
    z80_pkg::flags_t   flags;

    logic [7:0]        m_reg [0:7]; // model registers by opcode index where slot 6 stays zero.
    z80_pkg::flags_t   m_f;
    logic [31:0]       lcg_state;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                mark = 0;

    tb_clock u_clk (.clk(clk));

    z80_exec_top dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .opcode    (opcode),
        .operand   (operand),
        .busy      (busy),
        .done      (done),
        .illegal   (illegal),
        .mem_write (mem_write),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data),
        .flags     (flags)
    );

    function automatic logic [7:0] next_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input string what, input z80_pkg::flags_t got,
                               input z80_pkg::flags_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %08b expected %08b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic model_step(input logic [7:0] op, input logic [7:0] imm);
        logic [7:0] a;
        logic [7:0] corr;
        logic       hi;
        a = m_reg[7];
        if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != 3'd6) begin
            m_reg[op[5:3]] = imm;
        end else if (op[7:6] == 2'b00 && op[2:0] == 3'b111) begin
            case (op[5:3])
                3'd0: begin
                    m_reg[7] = {a[6:0], a[7]};
                    m_f.c    = a[7];
                end
                3'd1: begin
                    m_reg[7] = {a[0], a[7:1]};
                    m_f.c    = a[0];
                end
                3'd2: begin
                    m_reg[7] = {a[6:0], m_f.c};
                    m_f.c    = a[7];
                end
                3'd3: begin
                    m_reg[7] = {m_f.c, a[7:1]};
                    m_f.c    = a[0];
                end
                3'd4: begin
                    hi   = m_f.c || (a > 8'h99);
                    corr = hi ? 8'h60 : 8'h00;
                    if (m_f.h || (a[3:0] > 4'd9)) begin
                        corr = corr + 8'h06;
                    end
                    if (m_f.n) begin
                        m_reg[7] = a - corr;
                        m_f.h    = m_f.h && (a[3:0] < 4'd6);
                    end else begin
                        m_reg[7] = a + corr;
                        m_f.h    = (a[3:0] > 4'd9);
                    end
                    m_f.c  = hi;
                    m_f.s  = m_reg[7][7];
                    m_f.z  = (m_reg[7] == 8'h00);
                    m_f.pv = ($countones(m_reg[7]) % 2 == 0);
                end
                3'd5: begin
                    m_reg[7] = ~a;
                    m_f.h    = 1'b1;
                    m_f.n    = 1'b1;
                end
                3'd6: begin
                    m_f.c = 1'b1;
                    m_f.h = 1'b0;
                    m_f.n = 1'b0;
                end
                default: begin
                    m_f.h = m_f.c;
                    m_f.c = ~m_f.c;
                    m_f.n = 1'b0;
                end
            endcase
            if (op[5:3] < 3'd4) begin
                m_f.h = 1'b0; // rotates clear H and N.
                m_f.n = 1'b0;
            end
        end
    endtask

    task automatic compare_all();
        for (int r = 0; r < 8; r++) begin
            @(posedge clk);
            rd_sel <= 3'(r);
            @(negedge clk);
            check_byte($sformatf("register %0d", r), rd_data, m_reg[r]);
        end
        check_flags("flags", flags, m_f);
    endtask

    task automatic run_instr(input logic [7:0] op, input logic [7:0] imm, input bit inject,
                             output int lat, output bit ill, output bit mw);
        int cycles;
        cycles = 0;
        lat = -1;
        ill = 1'b0;
        mw = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        opcode <= op;
        operand <= imm;
        while (lat < 0 && cycles < 12) begin
            @(posedge clk);
            start <= 1'b0;
            if (inject && cycles == 1) begin
                start <= 1'b1; // arrives in T2 and must be dropped.
                opcode <= next_byte();
                operand <= next_byte();
            end
            @(negedge clk);
            cycles++;
            if (cycles <= 3) begin
                check_bit("busy", busy, 1'b1);
            end
            if (done) begin
                lat = cycles;
                ill = illegal;
                mw = mem_write;
            end
        end
        if (lat < 0) begin
            $display("timeout: no done within %0d cycles for opcode %02h", cycles, op);
            errors++;
        end
    endtask

    task automatic exec_op(input logic [7:0] op, input logic [7:0] imm, input bit inject);
        int lat;
        bit ill;
        bit mw;
        bit grp_ok;
        run_instr(op, imm, inject, lat, ill, mw);
        grp_ok = (op[7:6] == 2'b00) && (op[2:1] == 2'b11);
        check_byte("done latency", 8'(lat), 8'd3);
        check_bit("illegal", ill, !grp_ok);
        check_bit("mem_write", mw, grp_ok && op[2:0] == 3'b110 && op[5:3] == 3'd6);
        model_step(op, imm);
        compare_all();
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-10s %s", name, (errors == mark) ? "ok" : "failed");
        mark = errors;
    endtask

    initial begin
        logic [7:0] pre;
        lcg_state = 32'd52473;
        reset = 1'b1;
        start = 1'b0;
        opcode = 8'h00;
        operand = 8'h00;
        rd_sel = 3'd0;
        for (int r = 0; r < 8; r++) m_reg[r] = 8'h00;
        m_f = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        compare_all();
        end_test("reset");
        for (int r = 0; r < 8; r++) exec_op({2'b00, 3'(r), 3'b110}, next_byte(), 1'b0);
        end_test("loads");
        for (int i = 0; i < 16; i++) begin
            pre = next_byte();
            exec_op(8'h3e, next_byte(), 1'b0);            // LD A,n
            exec_op(8'h37, 8'h00, 1'b0);                  // SCF
            if (pre[0]) exec_op(8'h3f, 8'h00, 1'b0);      // CCF
            exec_op({3'b000, 2'(i), 3'b111}, 8'h00, 1'b0);
        end
        end_test("rotates");
        for (int i = 0; i < 24; i++) begin
            pre = next_byte();
            exec_op(8'h3e, next_byte(), 1'b0);
            if (pre[0]) exec_op(8'h2f, 8'h00, 1'b0); // CPL leaves N set for DAA.
            if (pre[1]) exec_op(8'h37, 8'h00, 1'b0);
            if (pre[2]) exec_op(8'h3f, 8'h00, 1'b0);
            exec_op({3'b001, pre[5] ? 2'b00 : pre[4:3], 3'b111}, 8'h00, 1'b0);
        end
        end_test("acc_ops");
        for (int i = 0; i < 12; i++) begin
            pre = next_byte();
            exec_op({2'b00, pre[5:3], 2'b11, pre[0]}, next_byte(), 1'b1);
            pre = next_byte();
            if (pre[7:6] == 2'b00 && pre[2:1] == 2'b11) pre[1] = 1'b0;
            exec_op(pre, next_byte(), 1'b0);
        end
        end_test("sequencing");
        for (int i = 0; i < 300; i++) begin
            pre = next_byte();
            exec_op({2'b00, pre[5:3], 2'b11, pre[0]}, next_byte(), 1'b0);
        end
        end_test("random");
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- sources.f
common/z80_pkg.sv
logic/reg_cell.sv
logic/read_mux.sv
logic/timing_sequencer.sv
decoder/op_decoder.sv
alu/accum_alu.sv
logic/z80_exec_top.sv
dv/tb_clock.sv
dv/exec_chk.sv
dv/exec_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module exec_tb -Mdir obj_dir

run: compile
	./obj_dir/Vexec_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
